/* common/action_consts.svh */
`ifndef ACTION_CONSTS_SVH
`define ACTION_CONSTS_SVH

// control stream beat layout
`define CTRL_DATA_W     256
`define CTRL_USER_W     128
`define CTRL_KEEP_W     32

// fields of the second beat of a control packet
`define MOD_ID_LSB      112
`define CTRL_FLAG_LSB   64
`define CTRL_INDEX_LSB  128

// flag value of a table-write packet
`define CTRL_FLAG_VAL   16'hf2f1

// upper five bits of the module id select the stage, lower three the engine
`define STAGE_ID        5'd0
`define ACTION_ID       3'd3

// page table geometry
`define PAGE_DEPTH      32
`define PAGE_ADDR_W     5
`define PAGE_W          16

// vlan id and where the table address sits inside it
`define VLAN_W          12
`define VLAN_PAGE_LSB   4

// phv layout
`define PHV_W           1024
`define PHV_VLAN_LSB    129

`endif

/* common/action_pkg.sv */
package action_pkg;

    `include "action_consts.svh"

    // one beat of the control stream, valid travels beside it
    typedef struct packed {
        logic [`CTRL_DATA_W-1:0] data;
        logic [`CTRL_KEEP_W-1:0] keep;
        logic [`CTRL_USER_W-1:0] user;
        logic                    last;
    } ctrl_beat_t;

    // one page table write
    typedef struct packed {
        logic                    en;
        logic [`PAGE_ADDR_W-1:0] addr;
        logic [`PAGE_W-1:0]      entry;
    } page_wr_t;

    // control filter states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_DECIDE,
        CTRL_FORWARD,
        CTRL_WRITE
    } ctrl_state_e;

    // lookup handshake states
    typedef enum logic {
        LOOKUP_IDLE,
        LOOKUP_READ
    } lookup_state_e;

    // vlan extraction states
    typedef enum logic {
        VLAN_IDLE,
        VLAN_HOLD
    } vlan_state_e;

endpackage

/* ctrl/ctrl_filter.sv */
`timescale 1ns/1ps
`include "action_consts.svh"

module ctrl_filter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  action_pkg::ctrl_beat_t  ctrl_in_i,
    input  logic                    ctrl_valid_i,
    output action_pkg::ctrl_beat_t  ctrl_out_o,
    output logic                    ctrl_valid_o,
    output action_pkg::page_wr_t    page_wr_o
);

    import action_pkg::*;

    ctrl_state_e             state_q;
    ctrl_state_e             state_d;
    ctrl_beat_t              held_q;
    logic                    load_held;
    logic                    emit;
    logic                    wr_fire;
    logic                    load_idx;

    logic [`PAGE_ADDR_W-1:0] wr_idx_q;
    logic                    wr_en_q;
    logic [`PAGE_ADDR_W-1:0] wr_addr_q;
    logic [`PAGE_W-1:0]      wr_entry_q;

    logic [7:0]              mod_id;
    logic [15:0]             ctrl_flag;
    logic                    is_cfg;

    // header fields, only meaningful on the second beat
    assign mod_id    = ctrl_in_i.data[`MOD_ID_LSB +: 8];
    assign ctrl_flag = ctrl_in_i.data[`CTRL_FLAG_LSB +: 16];
    assign is_cfg    = (mod_id[7:3] == `STAGE_ID) &&
                       (mod_id[2:0] == `ACTION_ID) &&
                       (ctrl_flag == `CTRL_FLAG_VAL);

    always_comb begin
        state_d   = state_q;
        load_held = 1'b0;
        emit      = 1'b0;
        wr_fire   = 1'b0;
        load_idx  = 1'b0;

        case (state_q)
            CTRL_IDLE: begin
                if (ctrl_valid_i) begin
                    load_held = 1'b1;
                    // single-beat packet goes straight out, no decode
                    state_d   = ctrl_in_i.last ? CTRL_FORWARD : CTRL_DECIDE;
                end
            end
            CTRL_DECIDE: begin
                if (ctrl_valid_i) begin
                    if (is_cfg) begin
                        // held beat one is dropped here
                        load_idx = 1'b1;
                        state_d  = ctrl_in_i.last ? CTRL_IDLE : CTRL_WRITE;
                    end else begin
                        emit      = 1'b1;
                        load_held = 1'b1;
                        state_d   = CTRL_FORWARD;
                    end
                end
            end
            CTRL_FORWARD: begin
                if (held_q.last) begin
                    emit = 1'b1;
                    if (ctrl_valid_i) begin
                        // back-to-back packet, this beat is its first
                        load_held = 1'b1;
                        state_d   = ctrl_in_i.last ? CTRL_FORWARD : CTRL_DECIDE;
                    end else begin
                        state_d = CTRL_IDLE;
                    end
                end else if (ctrl_valid_i) begin
                    emit      = 1'b1;
                    load_held = 1'b1;
                end
            end
            CTRL_WRITE: begin
                if (ctrl_valid_i) begin
                    wr_fire = 1'b1;
                    if (ctrl_in_i.last) begin
                        state_d = CTRL_IDLE;
                    end
                end
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= CTRL_IDLE;
            ctrl_valid_o <= 1'b0;
            wr_en_q      <= 1'b0;
            wr_idx_q     <= '0;
        end else begin
            state_q      <= state_d;
            ctrl_valid_o <= emit;
            wr_en_q      <= wr_fire;
            if (load_idx) begin
                wr_idx_q <= ctrl_in_i.data[`CTRL_INDEX_LSB +: `PAGE_ADDR_W];
            end else if (wr_fire) begin
                // wraps at the table size
                wr_idx_q <= wr_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_held) begin
            held_q <= ctrl_in_i;
        end
        if (emit) begin
            ctrl_out_o <= held_q;
        end
        if (wr_fire) begin
            wr_addr_q  <= wr_idx_q;
            // byte 0 is the high byte of the entry
            wr_entry_q <= {ctrl_in_i.data[7:0], ctrl_in_i.data[15:8]};
        end
    end

    assign page_wr_o.en    = wr_en_q;
    assign page_wr_o.addr  = wr_addr_q;
    assign page_wr_o.entry = wr_entry_q;

    // a packet is either forwarded or consumed, never both at once
    a_no_emit_and_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl_valid_o && page_wr_o.en)
    );

endmodule

/* hw/page_table.sv */
`timescale 1ns/1ps
`include "action_consts.svh"

module page_table (
    input  logic                    clk,
    input  action_pkg::page_wr_t    wr_i,
    input  logic [`PAGE_ADDR_W-1:0] rd_addr_i,
    output logic [`PAGE_W-1:0]      rd_data_o
);

    logic [`PAGE_W-1:0] mem [`PAGE_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.entry;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* hw/page_lookup.sv */
`timescale 1ns/1ps
`include "action_consts.svh"

module page_lookup (
    input  logic                 clk,
    input  logic                 rst_n,
    input  action_pkg::page_wr_t page_wr_i,
    input  logic [`VLAN_W-1:0]   vlan_id_i,
    input  logic                 vlan_valid_i,
    output logic                 vlan_ready_o,
    output logic [`PAGE_W-1:0]   page_entry_o,
    output logic                 page_valid_o
);

    import action_pkg::*;

    lookup_state_e           state_q;
    logic [`PAGE_ADDR_W-1:0] addr_q;
    logic                    accept;

    assign vlan_ready_o = (state_q == LOOKUP_IDLE);
    assign accept       = vlan_valid_i && vlan_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= LOOKUP_IDLE;
            page_valid_o <= 1'b0;
        end else begin
            page_valid_o <= 1'b0;
            case (state_q)
                LOOKUP_IDLE: begin
                    if (accept) begin
                        state_q <= LOOKUP_READ;
                    end
                end
                LOOKUP_READ: begin
                    // read data lands on this edge too
                    page_valid_o <= 1'b1;
                    state_q      <= LOOKUP_IDLE;
                end
                default: begin
                    state_q <= LOOKUP_IDLE;
                end
            endcase
        end
    end

    // address stays put so the entry holds after the pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= vlan_id_i[`VLAN_PAGE_LSB +: `PAGE_ADDR_W];
        end
    end

    page_table u_page_table (
        .clk       (clk),
        .wr_i      (page_wr_i),
        .rd_addr_i (addr_q),
        .rd_data_o (page_entry_o)
    );

    a_page_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        page_valid_o |=> !page_valid_o
    );

endmodule

/* hw/phv_vlan_extract.sv */
`timescale 1ns/1ps
`include "action_consts.svh"

module phv_vlan_extract (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`PHV_W-1:0]  phv_i,
    input  logic               phv_valid_i,
    output logic [`VLAN_W-1:0] vlan_o,
    output logic               vlan_out_valid_o,
    input  logic               vlan_out_ready_i
);

    import action_pkg::*;

    vlan_state_e state_q;
    logic        capture;

    // later phvs are dropped while one vlan is pending
    assign capture = (state_q == VLAN_IDLE) && phv_valid_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q          <= VLAN_IDLE;
            vlan_out_valid_o <= 1'b0;
        end else begin
            vlan_out_valid_o <= 1'b0;
            case (state_q)
                VLAN_IDLE: begin
                    if (capture) begin
                        state_q <= VLAN_HOLD;
                    end
                end
                VLAN_HOLD: begin
                    if (vlan_out_ready_i) begin
                        vlan_out_valid_o <= 1'b1;
                        state_q          <= VLAN_IDLE;
                    end
                end
                default: begin
                    state_q <= VLAN_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            vlan_o <= phv_i[`PHV_VLAN_LSB +: `VLAN_W];
        end
    end

    a_vlan_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        vlan_out_valid_o |=> !vlan_out_valid_o
    );

endmodule

/* hw/action_engine_top.sv */
`timescale 1ns/1ps
`include "action_consts.svh"

module action_engine_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // control stream
    input  action_pkg::ctrl_beat_t ctrl_in_i,
    input  logic                   ctrl_valid_i,
    output action_pkg::ctrl_beat_t ctrl_out_o,
    output logic                   ctrl_valid_o,

    // vlan to page lookup
    input  logic [`VLAN_W-1:0]     vlan_id_i,
    input  logic                   vlan_valid_i,
    output logic                   vlan_ready_o,
    output logic [`PAGE_W-1:0]     page_entry_o,
    output logic                   page_valid_o,

    // phv side
    input  logic [`PHV_W-1:0]      phv_i,
    input  logic                   phv_valid_i,
    output logic [`VLAN_W-1:0]     vlan_o,
    output logic                   vlan_out_valid_o,
    input  logic                   vlan_out_ready_i
);

    import action_pkg::*;

    // table writes from the config decoder
    page_wr_t page_wr;

    ctrl_filter u_ctrl_filter (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl_in_i    (ctrl_in_i),
        .ctrl_valid_i (ctrl_valid_i),
        .ctrl_out_o   (ctrl_out_o),
        .ctrl_valid_o (ctrl_valid_o),
        .page_wr_o    (page_wr)
    );

    page_lookup u_page_lookup (
        .clk          (clk),
        .rst_n        (rst_n),
        .page_wr_i    (page_wr),
        .vlan_id_i    (vlan_id_i),
        .vlan_valid_i (vlan_valid_i),
        .vlan_ready_o (vlan_ready_o),
        .page_entry_o (page_entry_o),
        .page_valid_o (page_valid_o)
    );

    phv_vlan_extract u_phv_vlan_extract (
        .clk              (clk),
        .rst_n            (rst_n),
        .phv_i            (phv_i),
        .phv_valid_i      (phv_valid_i),
        .vlan_o           (vlan_o),
        .vlan_out_valid_o (vlan_out_valid_o),
        .vlan_out_ready_i (vlan_out_ready_i)
    );

endmodule

/* tb/tb_action_engine.sv */
`timescale 1ns/1ps
`include "action_consts.svh"

module tb_action_engine;

    import action_pkg::*;

    localparam int         MAX_CYCLES = 3000;
    localparam logic [7:0] CFG_MOD_ID = {`STAGE_ID, `ACTION_ID};

    logic               clk;
    logic               rst_n;
    ctrl_beat_t         ctrl_in;
    logic               ctrl_valid;
    ctrl_beat_t         ctrl_out;
    logic               ctrl_out_valid;
    logic [`VLAN_W-1:0] vlan_id;
    logic               vlan_valid;
    logic               vlan_ready;
    logic [`PAGE_W-1:0] page_entry;
    logic               page_valid;
    logic [`PHV_W-1:0]  phv;
    logic               phv_valid;
    logic [`VLAN_W-1:0] vlan_out;
    logic               vlan_out_valid;
    logic               vlan_out_ready;

    logic [31:0]        rng;
    int                 cycle_count = 0;
    int                 err_count = 0;
    int                 test_errs = 0;
    int                 test_count = 0;
    int                 vlan_pulses = 0;
    string              cur_test = "reset";
    ctrl_beat_t         exp_q[$];
    ctrl_beat_t         pkt_q[$];
    logic [`PAGE_W-1:0] shadow [`PAGE_DEPTH];
    bit                 written [`PAGE_DEPTH];

    action_engine_top dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .ctrl_in_i        (ctrl_in),
        .ctrl_valid_i     (ctrl_valid),
        .ctrl_out_o       (ctrl_out),
        .ctrl_valid_o     (ctrl_out_valid),
        .vlan_id_i        (vlan_id),
        .vlan_valid_i     (vlan_valid),
        .vlan_ready_o     (vlan_ready),
        .page_entry_o     (page_entry),
        .page_valid_o     (page_valid),
        .phv_i            (phv),
        .phv_valid_i      (phv_valid),
        .vlan_o           (vlan_out),
        .vlan_out_valid_o (vlan_out_valid),
        .vlan_out_ready_i (vlan_out_ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: test %s hung after %0d cycles", cur_test, cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic ctrl_beat_t random_beat(input logic last);
        ctrl_beat_t b;
        for (int i = 0; i < 8; i++) begin
            b.data[i*32 +: 32] = next_rand();
        end
        for (int i = 0; i < 4; i++) begin
            b.user[i*32 +: 32] = next_rand();
        end
        b.keep = next_rand();
        b.last = last;
        return b;
    endfunction

    task automatic expect_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s: %s", cur_test, what);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %s finished with %0d errors", cur_test, test_errs);
    endtask

    // every forwarded beat must match the oldest expected one
    always @(negedge clk) begin
        if (rst_n && ctrl_out_valid) begin
            if (exp_q.size() == 0) begin
                expect_true(1'b0, "a beat came out although none was expected");
            end else begin
                assert (ctrl_out === exp_q[0]) else begin
                    $display("Mismatch %s ctrl beat: expected %h actual %h",
                             cur_test, exp_q[0], ctrl_out);
                    err_count++;
                    test_errs++;
                end
                void'(exp_q.pop_front());
            end
        end
        if (rst_n && vlan_out_valid) begin
            vlan_pulses++;
        end
    end

    task automatic queue_plain(input int beats);
        ctrl_beat_t b;
        pkt_q.delete();
        for (int i = 0; i < beats; i++) begin
            b = random_beat(i == beats - 1);
            // keep random headers away from this engine's id
            if (b.data[`MOD_ID_LSB +: 8] == CFG_MOD_ID) begin
                b.data[`MOD_ID_LSB + 7] = 1'b1;
            end
            pkt_q.push_back(b);
        end
    endtask

    task automatic queue_header_packet(input logic [7:0] mod_id, input logic [15:0] flag,
                                       input int idx, input int payload,
                                       input bit table_write);
        ctrl_beat_t b;
        int         addr;
        pkt_q.delete();
        pkt_q.push_back(random_beat(1'b0));
        b = random_beat(payload == 0);
        b.data[`MOD_ID_LSB +: 8]     = mod_id;
        b.data[`CTRL_FLAG_LSB +: 16] = flag;
        b.data[`CTRL_INDEX_LSB +: 8] = idx[7:0];
        pkt_q.push_back(b);
        for (int i = 0; i < payload; i++) begin
            b = random_beat(i == payload - 1);
            pkt_q.push_back(b);
            if (table_write) begin
                addr = (idx + i) % `PAGE_DEPTH;
                // byte 0 is the high byte of the entry
                shadow[addr]  = {b.data[7:0], b.data[15:8]};
                written[addr] = 1'b1;
            end
        end
    endtask

    task automatic send_packet(input bit forwarded);
        ctrl_beat_t b;
        while (pkt_q.size() > 0) begin
            b = pkt_q.pop_front();
            if (forwarded) begin
                exp_q.push_back(b);
            end
            @(posedge clk);
            ctrl_in    <= b;
            ctrl_valid <= 1'b1;
        end
    endtask

    task automatic idle_ctrl(input int cycles);
        @(posedge clk);
        ctrl_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic do_lookup(input int addr);
        logic [31:0]        r;
        logic [`VLAN_W-1:0] id;
        r  = next_rand();
        id = r[`VLAN_W-1:0];
        id[`VLAN_PAGE_LSB +: `PAGE_ADDR_W] = addr[`PAGE_ADDR_W-1:0];
        @(posedge clk);
        vlan_id    <= id;
        vlan_valid <= 1'b1;
        @(negedge clk);
        while (!vlan_ready) begin
            @(negedge clk);
        end
        // accepting edge
        @(posedge clk);
        vlan_valid <= 1'b0;
        @(negedge clk);
        expect_true(!vlan_ready, "vlan_ready_o stayed high after acceptance");
        expect_true(!page_valid, "page_valid_o came too early");
        @(negedge clk);
        expect_true(page_valid, "page_valid_o did not pulse");
        expect_true(vlan_ready, "vlan_ready_o stayed low for more than one cycle");
        expect_eq("page entry", 32'(shadow[addr]), 32'(page_entry));
    endtask

    initial begin
        logic [`PHV_W-1:0]  phv_a;
        logic [`PHV_W-1:0]  phv_b;
        logic [`VLAN_W-1:0] field_a;
        ctrl_beat_t         hdr;
        rng            = 32'h3957465b;
        clk            = 1'b0;
        rst_n          = 1'b0;
        ctrl_in        = '0;
        ctrl_valid     = 1'b0;
        vlan_id        = '0;
        vlan_valid     = 1'b0;
        phv            = '0;
        phv_valid      = 1'b0;
        vlan_out_ready = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset");
        @(negedge clk);
        expect_true(!ctrl_out_valid, "ctrl_valid_o high after reset");
        expect_true(!page_valid, "page_valid_o high after reset");
        expect_true(!vlan_out_valid, "vlan_out_valid_o high after reset");
        expect_true(vlan_ready, "vlan_ready_o low after reset");
        end_test();

        begin_test("forward");
        queue_plain(1);
        send_packet(1'b1);
        queue_plain(4);
        // first beat carries this engine's header fields
        hdr = pkt_q.pop_front();
        hdr.data[`MOD_ID_LSB +: 8]     = CFG_MOD_ID;
        hdr.data[`CTRL_FLAG_LSB +: 16] = `CTRL_FLAG_VAL;
        pkt_q.push_front(hdr);
        send_packet(1'b1);
        queue_header_packet({5'd1, `ACTION_ID}, `CTRL_FLAG_VAL, 0, 2, 1'b0);
        send_packet(1'b1);
        queue_header_packet(CFG_MOD_ID, 16'hf2f0, 0, 2, 1'b0);
        send_packet(1'b1);
        queue_plain(3);
        send_packet(1'b1);
        idle_ctrl(6);
        expect_true(exp_q.size() == 0, "forwarded beats are missing");
        end_test();

        begin_test("table_write");
        queue_header_packet(CFG_MOD_ID, `CTRL_FLAG_VAL, 5, 4, 1'b1);
        send_packet(1'b0);
        queue_plain(3);
        send_packet(1'b1);
        // index wraps past the last entry
        queue_header_packet(CFG_MOD_ID, `CTRL_FLAG_VAL, 30, 4, 1'b1);
        send_packet(1'b0);
        queue_plain(2);
        send_packet(1'b1);
        idle_ctrl(6);
        expect_true(exp_q.size() == 0, "forwarded beats are missing");
        end_test();

        begin_test("lookup");
        for (int a = 0; a < `PAGE_DEPTH; a++) begin
            if (written[a]) begin
                do_lookup(a);
            end
        end
        end_test();

        begin_test("vlan_extract");
        for (int i = 0; i < `PHV_W / 32; i++) begin
            phv_a[i*32 +: 32] = next_rand();
            phv_b[i*32 +: 32] = next_rand();
        end
        field_a = phv_a[`PHV_VLAN_LSB +: `VLAN_W];
        if (phv_b[`PHV_VLAN_LSB +: `VLAN_W] == field_a) begin
            phv_b[`PHV_VLAN_LSB] = ~phv_b[`PHV_VLAN_LSB];
        end
        @(posedge clk);
        phv       <= phv_a;
        phv_valid <= 1'b1;
        @(posedge clk);
        phv_valid <= 1'b0;
        repeat (3) @(posedge clk);
        phv       <= phv_b;
        phv_valid <= 1'b1;
        @(posedge clk);
        phv_valid <= 1'b0;
        repeat (3) @(posedge clk);
        expect_true(vlan_pulses == 0, "vlan_out_valid_o pulsed while ready was low");
        vlan_out_ready <= 1'b1;
        @(negedge clk);
        expect_true(!vlan_out_valid, "vlan_out_valid_o came too early");
        @(negedge clk);
        expect_true(vlan_out_valid, "vlan_out_valid_o did not pulse");
        expect_eq("vlan", 32'(field_a), 32'(vlan_out));
        repeat (4) @(negedge clk);
        expect_eq("vlan pulse count", 32'd1, 32'(vlan_pulses));
        end_test();

        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/action_pkg.sv
ctrl/ctrl_filter.sv
hw/page_table.sv
hw/page_lookup.sv
hw/phv_vlan_extract.sv
hw/action_engine_top.sv
tb/tb_action_engine.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_action_engine \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
